// ==== rtl/cga_consts.svh ====
// ======================================================================
// Character cell, font RAM and colour field sizes
// Shared by the sequencer, the pixel block and the attribute block
// ======================================================================
`ifndef CGA_CONSTS_SVH
`define CGA_CONSTS_SVH

// Pixels in one character cell, also the byte width of VRAM data
`define CGA_CHAR_W 8

// Glyph rows per character and the row address width
`define CGA_GLYPH_ROWS 8
`define CGA_ROW_W $clog2(`CGA_GLYPH_ROWS)

// Font RAM addressed as {character code, glyph row}
`define CGA_FONT_AW 11
`define CGA_FONT_DEPTH (1 << `CGA_FONT_AW)

// IRGB colour width
`define CGA_COLOR_W 4

`endif

// ==== rtl/cga_mode_pkg.sv ====
// ======================================================================
// Display mode selection and the IRGB pixel colour type
// ======================================================================
`default_nettype none

package cga_mode_pkg;

    // Text mode uses the font RAM, graphics mode is the 320-wide
    // four colour mode with two bits per pixel
    typedef enum logic {
        MODE_TEXT   = 1'b0,
        MODE_GRAPH4 = 1'b1
    } video_mode_e;

    // Same bit order as the CGA colour nibble
    // Intensity sits in the top bit
    typedef struct packed {
        logic i;
        logic r;
        logic g;
        logic b;
    } irgb_t;

endpackage

`default_nettype wire

// ==== rtl/cga_timing_pkg.sv ====
// ======================================================================
// Character cell phase encoding, one value per clock of a cell
// ======================================================================
`default_nettype none

package cga_timing_pkg;

    // Values double as the pixel index inside the displayed cell
    typedef enum logic [2:0] {
        PH_CHAR  = 3'd0,  // Character byte fetch
        PH_ATTR  = 3'd1,  // Attribute byte fetch
        PH_FONT  = 3'd2,  // Glyph row read
        PH_IDLE3 = 3'd3,
        PH_IDLE4 = 3'd4,
        PH_IDLE5 = 3'd5,
        PH_IDLE6 = 3'd6,
        PH_LOAD  = 3'd7   // Fetch registers copied to display registers
    } char_phase_e;

endpackage

`default_nettype wire

// ==== rtl/cga_char_seq.sv ====
// ======================================================================
// Character cell sequencer
// Phase counter with registered fetch, font read and load strobes
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cga_consts.svh"

module cga_char_seq (
    input  wire                         clk,
    input  wire                         rst_n,
    output cga_timing_pkg::char_phase_e phase,
    output logic                        read_char,
    output logic                        read_att,
    output logic                        font_read,
    output logic                        load
);

    import cga_timing_pkg::*;

    // Last phase of a cell, one clock per pixel
    localparam int LAST_PHASE = `CGA_CHAR_W - 1;

    // Set once the first character has been fetched
    // Keeps load quiet while the fetch registers hold nothing
    logic primed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_CHAR;
            read_char <= 1'b0;
            read_att  <= 1'b0;
            font_read <= 1'b0;
            load      <= 1'b0;
            primed    <= 1'b0;
        end else begin
            if (phase == char_phase_e'(LAST_PHASE)) begin
                phase <= PH_CHAR;
            end else begin
                phase <= char_phase_e'(phase + 3'd1);
            end

            // Each strobe is decoded one clock early so it is high
            // exactly during its own phase
            read_char <= (phase == PH_LOAD);

            // Attribute and font strobes only follow a real character fetch
            read_att  <= read_char && (phase == PH_CHAR);
            font_read <= read_att && (phase == PH_ATTR);
            load      <= primed && (phase == PH_IDLE6);

            if (read_char) begin
                primed <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cga_pixel.sv ====
// ======================================================================
// Pixel fetch and select
// VRAM byte latches, writable font RAM, display registers and
// per-phase pixel selection for text and graphics modes
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cga_consts.svh"

module cga_pixel (
    input  wire                         clk,
    input  wire                         rst_n,
    input  cga_mode_pkg::video_mode_e   mode,
    input  cga_timing_pkg::char_phase_e phase,
    input  wire                         read_char,
    input  wire                         read_att,
    input  wire                         font_read,
    input  wire                         load,
    input  wire [`CGA_CHAR_W-1:0]       vram_data,
    input  wire [`CGA_ROW_W-1:0]        row_addr,
    input  wire                         cursor,
    input  wire                         display_enable,
    input  wire                         font_wr,
    input  wire [`CGA_FONT_AW-1:0]      font_addr,
    input  wire [`CGA_CHAR_W-1:0]       font_data,
    output logic                        pix_on,
    output logic [1:0]                  pix_bits,
    output logic [`CGA_CHAR_W-1:0]      attr_q,
    output logic                        cursor_q,
    output logic                        de_q
);

    import cga_mode_pkg::*;

    // Fetch side, filled during the first phases of a cell
    logic [`CGA_CHAR_W-1:0] char_f;
    logic [`CGA_CHAR_W-1:0] attr_f;
    logic [`CGA_CHAR_W-1:0] glyph_f;
    logic [`CGA_ROW_W-1:0]  row_f;
    logic                   cursor_f;
    logic                   de_f;

    // Display side, stable for the whole cell being shown
    logic [`CGA_CHAR_W-1:0] char_q;
    logic [`CGA_CHAR_W-1:0] glyph_q;

    logic [`CGA_CHAR_W-1:0] font_ram [`CGA_FONT_DEPTH];

    // Font port writes and glyph reads share the RAM
    always_ff @(posedge clk) begin
        if (font_wr) begin
            font_ram[font_addr] <= font_data;
        end
        if (font_read) begin
            glyph_f <= font_ram[{char_f, row_f}];
        end
    end

    // VRAM bytes arrive on the edge that ends their strobe
    always_ff @(posedge clk) begin
        if (read_char) begin
            char_f <= vram_data;
            row_f  <= row_addr;
        end
        if (read_att) begin
            attr_f <= vram_data;
        end
    end

    // Per-cell controls sampled with the character byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor_f <= 1'b0;
            de_f     <= 1'b0;
        end else if (read_char) begin
            cursor_f <= cursor;
            de_f     <= display_enable;
        end
    end

    // Load point, frees the fetch registers for the next character
    // Reset values give a black text cell before the first load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            char_q   <= '0;
            glyph_q  <= '0;
            attr_q   <= '0;
            cursor_q <= 1'b0;
            de_q     <= 1'b1;
        end else if (load) begin
            char_q   <= char_f;
            glyph_q  <= glyph_f;
            attr_q   <= attr_f;
            cursor_q <= cursor_f;
            de_q     <= de_f;
        end
    end

    // Phase picks the pixel, leftmost pixel from bit 7
    always_comb begin
        pix_on   = (mode == MODE_TEXT) && glyph_q[3'd7 - phase];
        pix_bits = 2'b00;
        if (mode == MODE_GRAPH4) begin
            // Character byte covers the left half of the cell
            if (phase[2] == 1'b0) begin
                pix_bits = char_q[{~phase[1:0], 1'b1} -: 2];
            end else begin
                pix_bits = attr_q[{~phase[1:0], 1'b1} -: 2];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cga_attrib.sv ====
// ======================================================================
// Attribute and palette stage
// Text colours, blink, cursor, graphics palettes and border,
// registered into the IRGB video output
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cga_consts.svh"

module cga_attrib (
    input  wire                       clk,
    input  wire                       rst_n,
    input  cga_mode_pkg::video_mode_e mode,
    input  wire                       pix_on,
    input  wire [1:0]                 pix_bits,
    input  wire [`CGA_CHAR_W-1:0]     attr_q,
    input  wire                       cursor_q,
    input  wire                       de_q,
    input  wire [7:0]                 color_reg,
    input  wire                       blink_enabled,
    input  wire                       blink,
    output cga_mode_pkg::irgb_t       video
);

    import cga_mode_pkg::*;

    irgb_t fg_raw;
    irgb_t fg;
    irgb_t bg;
    irgb_t border;
    irgb_t text_color;
    irgb_t graph_color;
    irgb_t next_video;

    // Background and border share the low nibble of the colour register
    assign border = irgb_t'(color_reg[`CGA_COLOR_W-1:0]);

    always_comb begin
        fg_raw = irgb_t'(attr_q[`CGA_COLOR_W-1:0]);

        // With blink enabled attr bit 7 is the blink flag,
        // otherwise it is background intensity
        if (blink_enabled) begin
            bg = irgb_t'({1'b0, attr_q[6:4]});
        end else begin
            bg = irgb_t'(attr_q[7:4]);
        end

        // Blinking characters vanish into the background
        fg = fg_raw;
        if (blink_enabled && attr_q[7] && blink) begin
            fg = bg;
        end

        // Cursor fills the whole cell in the unblinked foreground
        if (cursor_q && blink) begin
            text_color = fg_raw;
        end else if (pix_on) begin
            text_color = fg;
        end else begin
            text_color = bg;
        end

        // Value 0 is background, 1..3 index the selected palette
        if (pix_bits == 2'b00) begin
            graph_color = border;
        end else begin
            graph_color = irgb_t'({color_reg[4], pix_bits, color_reg[5]});
        end

        if (!de_q) begin
            next_video = border;
        end else if (mode == MODE_GRAPH4) begin
            next_video = graph_color;
        end else begin
            next_video = text_color;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video <= next_video;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cga_video_top.sv ====
// ======================================================================
// Pixel pipeline top level
// Sequencer, pixel fetch block and attribute stage
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cga_consts.svh"

module cga_video_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  cga_mode_pkg::video_mode_e   mode,
    input  wire [7:0]                   color_reg,
    input  wire                         blink_enabled,
    input  wire                         blink,
    input  wire                         font_wr,
    input  wire [`CGA_FONT_AW-1:0]      font_addr,
    input  wire [`CGA_CHAR_W-1:0]       font_data,
    input  wire [`CGA_CHAR_W-1:0]       vram_data,
    input  wire                         display_enable,
    input  wire                         cursor,
    input  wire [`CGA_ROW_W-1:0]        row_addr,
    output logic                        read_char,
    output logic                        read_att,
    output cga_mode_pkg::irgb_t         video,
    output cga_timing_pkg::char_phase_e phase
);

    // Sequencer strobes used only inside
    logic font_read;
    logic load;

    // Display-side pixel data into the attribute stage
    logic                   pix_on;
    logic [1:0]             pix_bits;
    logic [`CGA_CHAR_W-1:0] attr_q;
    logic                   cursor_q;
    logic                   de_q;

    cga_char_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .read_char (read_char),
        .read_att  (read_att),
        .font_read (font_read),
        .load      (load)
    );

    cga_pixel u_pixel (
        .clk            (clk),
        .rst_n          (rst_n),
        .mode           (mode),
        .phase          (phase),
        .read_char      (read_char),
        .read_att       (read_att),
        .font_read      (font_read),
        .load           (load),
        .vram_data      (vram_data),
        .row_addr       (row_addr),
        .cursor         (cursor),
        .display_enable (display_enable),
        .font_wr        (font_wr),
        .font_addr      (font_addr),
        .font_data      (font_data),
        .pix_on         (pix_on),
        .pix_bits       (pix_bits),
        .attr_q         (attr_q),
        .cursor_q       (cursor_q),
        .de_q           (de_q)
    );

    cga_attrib u_attrib (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .pix_on        (pix_on),
        .pix_bits      (pix_bits),
        .attr_q        (attr_q),
        .cursor_q      (cursor_q),
        .de_q          (de_q),
        .color_reg     (color_reg),
        .blink_enabled (blink_enabled),
        .blink         (blink),
        .video         (video)
    );

endmodule

`default_nettype wire

// ==== bench/cga_video_properties.sv ====
// ======================================================================
// Concurrent checks on the sequencer strobes and the video output
// Bound into the pixel pipeline top level
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cga_video_properties (
    input wire                 clk,
    input wire                 rst_n,
    input wire                 read_char,
    input wire                 read_att,
    input cga_mode_pkg::irgb_t video
);

    // One character fetch per cell of eight clocks
    property p_char_spacing;
        @(posedge clk) disable iff (!rst_n)
            read_char |=> (!read_char) [*7] ##1 read_char;
    endproperty

    // Character and attribute fetches use separate phases
    property p_fetch_exclusive;
        @(posedge clk) disable iff (!rst_n)
            !(read_char && read_att);
    endproperty

    // Every pixel out of reset carries a defined colour
    property p_video_known;
        @(posedge clk) disable iff (!rst_n)
            !$isunknown(video);
    endproperty

    a_char_spacing: assert property (p_char_spacing)
        else $error("read_char pulses are not 8 cycles apart");

    a_fetch_exclusive: assert property (p_fetch_exclusive)
        else $error("read_char and read_att are high in the same cycle");

    a_video_known: assert property (p_video_known)
        else $error("video output has unknown bits");

endmodule

`default_nettype wire

// ==== bench/cga_video_tb.sv ====
// ======================================================================
// Testbench for the CGA pixel pipeline
// Reads font and character records, loads the font RAM, streams
// characters back to back and checks every pixel at fixed latency
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cga_consts.svh"

module cga_video_tb;

    import cga_mode_pkg::*;
    import cga_timing_pkg::*;

    localparam string INPUT_FILE = "bench/cga_video_input.txt";
    localparam int    SEED       = 60729;
    // Cycles from read_char to the first pixel on video
    localparam int    PIXEL_LATENCY = 9;

    logic                    clk;
    logic                    rst_n;
    video_mode_e             mode;
    logic [7:0]              color_reg;
    logic                    blink_enabled;
    logic                    blink;
    logic                    font_wr;
    logic [`CGA_FONT_AW-1:0] font_addr;
    logic [`CGA_CHAR_W-1:0]  font_data;
    logic [`CGA_CHAR_W-1:0]  vram_data;
    logic                    display_enable;
    logic                    cursor;
    logic [`CGA_ROW_W-1:0]   row_addr;
    logic                    read_char;
    logic                    read_att;
    irgb_t                   video;
    char_phase_e             phase;

    // Font records, address is {character code, glyph row}
    logic [`CGA_FONT_AW-1:0] font_rec_addr [$];
    logic [`CGA_CHAR_W-1:0]  font_rec_data [$];

    // Character records with eight expected pixels, pixel 0 in the top nibble
    string                   rec_name [$];
    logic                    rec_mode [$];
    logic [7:0]              rec_color [$];
    logic                    rec_blink_en [$];
    logic                    rec_blink [$];
    logic                    rec_cursor [$];
    logic                    rec_de [$];
    logic [`CGA_ROW_W-1:0]   rec_row [$];
    logic [7:0]              rec_char [$];
    logic [7:0]              rec_attr [$];
    logic [31:0]             rec_pixels [$];

    // Records whose pixels are still to come, oldest first
    int pend_rec [$];
    int pend_base [$];

    // Video must stay black until the first record is on its way
    logic stream_started = 1'b0;

    int cycles = 0;
    int cycle_limit = 1000000;
    int check_count = 0;
    int mismatch_count = 0;
    int other_errors = 0;

    cga_video_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .mode           (mode),
        .color_reg      (color_reg),
        .blink_enabled  (blink_enabled),
        .blink          (blink),
        .font_wr        (font_wr),
        .font_addr      (font_addr),
        .font_data      (font_data),
        .vram_data      (vram_data),
        .display_enable (display_enable),
        .cursor         (cursor),
        .row_addr       (row_addr),
        .read_char      (read_char),
        .read_att       (read_att),
        .video          (video),
        .phase          (phase)
    );

    bind cga_video_top cga_video_properties u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .read_char (read_char),
        .read_att  (read_att),
        .video     (video)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch in %s: expected %h, actual %h",
                     name, expected, actual);
        end
    endtask

    task automatic read_input_file();
        int                      fd;
        int                      code;
        string                   tag;
        string                   name;
        int                      mode_val;
        int                      be_val;
        int                      blink_val;
        int                      cursor_val;
        int                      de_val;
        int                      row_val;
        logic [7:0]              color_val;
        logic [7:0]              char_val;
        logic [7:0]              attr_val;
        logic [`CGA_FONT_AW-1:0] addr_val;
        logic [7:0]              data_val;
        logic [31:0]             pixels_val;
        logic [8*256-1:0]        skip_line;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Error: cannot open the input file %s", INPUT_FILE);
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag.substr(0, 0) == "#") begin
                    // Column description, rest of the line is dropped
                    code = $fgets(skip_line, fd);
                end else if (tag == "F") begin
                    code = $fscanf(fd, "%h %h", addr_val, data_val);
                    if (code == 2) begin
                        font_rec_addr.push_back(addr_val);
                        font_rec_data.push_back(data_val);
                    end else begin
                        other_errors++;
                        $display("Error: a font record in the input file is malformed");
                    end
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%s %d %h %d %d %d %d %d %h %h %h", name, mode_val,
                                   color_val, be_val, blink_val, cursor_val, de_val,
                                   row_val, char_val, attr_val, pixels_val);
                    if (code == 11) begin
                        rec_name.push_back(name);
                        rec_mode.push_back(mode_val[0]);
                        rec_color.push_back(color_val);
                        rec_blink_en.push_back(be_val[0]);
                        rec_blink.push_back(blink_val[0]);
                        rec_cursor.push_back(cursor_val[0]);
                        rec_de.push_back(de_val[0]);
                        rec_row.push_back(row_val[`CGA_ROW_W-1:0]);
                        rec_char.push_back(char_val);
                        rec_attr.push_back(attr_val);
                        rec_pixels.push_back(pixels_val);
                    end else begin
                        other_errors++;
                        $display("Error: a character record in the input file is malformed");
                    end
                end else begin
                    other_errors++;
                    $display("Error: unknown record type %s in the input file", tag);
                end
            end
            $fclose(fd);
        end
        if (rec_name.size() == 0) begin
            other_errors++;
            $display("Error: no character records were read from the input file");
        end
    endtask

    // Whole RAM gets random rows, then the glyph rows under test
    task automatic load_font();
        int a;
        for (a = 0; a < `CGA_FONT_DEPTH; a++) begin
            font_wr   = 1'b1;
            font_addr = a[`CGA_FONT_AW-1:0];
            font_data = 8'($urandom);
            @(posedge clk);
            #2;
        end
        for (a = 0; a < font_rec_addr.size(); a++) begin
            font_wr   = 1'b1;
            font_addr = font_rec_addr[a];
            font_data = font_rec_data[a];
            @(posedge clk);
            #2;
        end
        font_wr = 1'b0;
    endtask

    // Returns just after the edge that starts a read_char cycle
    task automatic wait_for_read_char();
        while (read_char !== 1'b1) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Per-character inputs, sampled by the DUT with the character byte
    task automatic present_record(input int k);
        vram_data      = rec_char[k];
        cursor         = rec_cursor[k];
        display_enable = rec_de[k];
        row_addr       = rec_row[k];
        stream_started = 1'b1;
        pend_rec.push_back(k);
        pend_base.push_back(cycles);
    endtask

    task automatic present_idle_cell();
        vram_data      = '0;
        cursor         = 1'b0;
        display_enable = 1'b0;
        row_addr       = '0;
    endtask

    // Global controls act while the previous character is on screen
    task automatic apply_display_controls(input int k);
        mode          = rec_mode[k] ? MODE_GRAPH4 : MODE_TEXT;
        color_reg     = rec_color[k];
        blink_enabled = rec_blink_en[k];
        blink         = rec_blink[k];
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Error: run stopped at cycle %0d, the pixel stream never completed",
                     cycles);
            $display("Checks %0d, mismatches %0d, other errors %0d",
                     check_count, mismatch_count, other_errors);
            $display("Test failures found");
            $finish;
        end
    end

    // Video is stable at the falling edge
    always @(negedge clk) begin : pixel_check
        int          pix;
        logic [31:0] word;
        if (rst_n && pend_base.size() > 0) begin
            if (cycles >= pend_base[0] + PIXEL_LATENCY) begin
                pix  = cycles - pend_base[0] - PIXEL_LATENCY;
                word = rec_pixels[pend_rec[0]];
                check_value($sformatf("%s pixel %0d", rec_name[pend_rec[0]], pix),
                            word[(7 - pix) * 4 +: 4], video);
                if (pix == `CGA_CHAR_W - 1) begin
                    void'(pend_rec.pop_front());
                    void'(pend_base.pop_front());
                end
            end
        end else if (rst_n && !stream_started) begin
            check_value("video before the first character", 4'h0, video);
        end
    end

    initial begin
        int k;
        rst_n          = 1'b0;
        mode           = MODE_TEXT;
        color_reg      = '0;
        blink_enabled  = 1'b0;
        blink          = 1'b0;
        font_wr        = 1'b0;
        font_addr      = '0;
        font_data      = '0;
        vram_data      = '0;
        display_enable = 1'b0;
        cursor         = 1'b0;
        row_addr       = '0;
        void'($urandom(SEED));

        read_input_file();
        // Reset, font load, one cell per record, plus fill and drain slack
        cycle_limit = 2 + `CGA_FONT_DEPTH + font_rec_addr.size()
                      + `CGA_CHAR_W * rec_name.size() + 64;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        load_font();

        // One extra cell shows the last record
        for (k = 0; k <= rec_name.size(); k++) begin
            wait_for_read_char();
            // Character fetch owns the first phase of the cell
            check_value("phase at read_char", 4'(PH_CHAR), 4'(phase));
            check_value("read_att at read_char", 4'd0, {3'b000, read_att});
            if (k < rec_name.size()) begin
                present_record(k);
            end else begin
                present_idle_cell();
            end
            if (k > 0) begin
                apply_display_controls(k - 1);
            end
            @(posedge clk);
            #2;
            // Attribute fetch follows one clock later
            check_value("read_att at PH_ATTR", 4'd1, {3'b000, read_att});
            check_value("phase at read_att", 4'(PH_ATTR), 4'(phase));
            vram_data = (k < rec_name.size()) ? rec_attr[k] : '0;
        end

        while (pend_base.size() > 0) begin
            @(posedge clk);
        end

        $display("Checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cga_video_input.txt ====
# F font_addr font_byte   (font address is character code then glyph row)
# C name mode color_reg blink_en blink cursor de row char attr pixels (pixel 0 leftmost digit)
F 20a 3c
F 215 a5
F 218 f0
F 6df 81
C txt_a 0 00 0 0 0 1 2 41 1e 11eeee11
C txt_b 0 00 0 0 0 1 5 42 07 70700707
C txt_bg_int 0 00 0 0 0 1 0 43 9a aaaa9999
C blink_hidden 0 00 1 1 0 1 0 43 9a 11111111
C blink_shown 0 00 1 0 0 1 0 43 9a aaaa1111
C blink_plain 0 00 1 1 0 1 2 41 2c 22cccc22
C cursor_on 0 00 0 1 1 1 2 41 1e eeeeeeee
C cursor_off 0 00 0 0 1 1 2 41 1e 11eeee11
C border_text 0 05 0 0 0 0 2 41 1e 55555555
C border_gfx 1 3c 0 0 0 0 0 1b e4 cccccccc
C gfx_pal0 1 01 0 0 0 1 0 1b e4 12466421
C gfx_pal1 1 20 0 0 0 1 0 1b e4 03577530
C gfx_pal0_int 1 18 0 0 0 1 0 1b e4 8aceeca8
C gfx_pal1_int 1 3f 0 0 0 1 0 1b e4 fbdffdbf
C mix_txt 0 00 0 0 0 1 7 db 4f f444444f
C mix_gfx 1 05 0 0 0 1 0 d8 27 62455426
C mix_txt_blink 0 00 1 1 0 1 5 42 70 07077070
C mix_border 0 0e 0 0 0 0 3 00 00 eeeeeeee

// ==== build.f ====
+incdir+rtl
rtl/cga_mode_pkg.sv
rtl/cga_timing_pkg.sv
rtl/cga_char_seq.sv
rtl/cga_pixel.sv
rtl/cga_attrib.sv
rtl/cga_video_top.sv
bench/cga_video_properties.sv
bench/cga_video_tb.sv
